// File: list.f
+incdir+verilog
verilog/vrc_bus_pkg.sv
verilog/vrc_irq_pkg.sv
verilog/reg_wr_if.sv
verilog/vrc_reg_decode.sv
verilog/vrc_bank_regs.sv
verilog/vrc_addr_map.sv
verilog/vrc_irq_prescaler.sv
verilog/vrc_irq_fsm.sv
verilog/vrc4_mapper.sv
tests/tb_vrc4_mapper.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timescale 1ns/1ps --top-module tb_vrc4_mapper -f list.f -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi
if ! ./obj_dir/sim_tb > sim.log 2>&1; then
	echo "Simulation run failed"
	exit 1
fi
if grep -q "No errors" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1

// File: tests/tb_vrc4_mapper.sv
// VRC4 mapper testbench

`timescale 1ns/1ps
`include "vrc_defs.svh"

module tb_vrc4_mapper import vrc_bus_pkg::*; ();

	localparam int WAIT_CYCLES = 1500;   // Well past two scanlines of strobes

	logic        clk;
	logic        rst;
	logic        cpu_ce;
	logic        prg_write;
	logic [15:0] prg_ain;
	logic [7:0]  prg_din;
	logic [13:0] chr_ain;
	vrc_board_t  board;
	logic        hard_mirror;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;
	logic [1:0]  ce_div;
	int          errors;
	int          test_errors;
	int          checks;
	int          tests;

	vrc4_mapper vrc4_mapper_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// One M2 strobe every three clocks
	always @(negedge clk) begin
		cpu_ce = (ce_div == 2'd2);
		ce_div = (ce_div == 2'd2) ? 2'd0 : ce_div + 2'd1;
	end

	task automatic report_mismatch(input string msg);
		errors++;
		test_errors++;
		$display("FAIL at %0t: %s", $time, msg);
	endtask

	task automatic check_prg(input logic [15:0] addr, input logic [21:0] got,
			input logic [21:0] exp, input logic got_allow, input logic exp_allow);
		checks++;
		if (got !== exp || got_allow !== exp_allow)
			report_mismatch($sformatf("PRG %h gave %h (bank %h) allow %b, expected %h allow %b",
				addr, got, got[13 +: `VRC_PRG_BANK_W], got_allow, exp, exp_allow));
	endtask

	task automatic check_chr(input logic [13:0] addr, input logic [21:0] got,
			input logic [21:0] exp, input logic [1:0] got_ciram, input logic [1:0] exp_ciram);
		checks++;
		if (got !== exp || got_ciram !== exp_ciram)
			report_mismatch($sformatf("CHR %h gave %h (page %h) a10/ce %b, expected %h a10/ce %b",
				addr, got, got[10 +: `VRC_CHR_BANK_W], got_ciram, exp, exp_ciram));
	endtask

	task automatic check_irq_count(input int got, input int exp);
		checks++;
		if (got == 0 && exp != 0) begin
			errors++;
			test_errors++;
			$display("irq did not rise within %0d cycles, expected after %0d strobes",
				WAIT_CYCLES, exp);
		end else if (got != exp) begin
			report_mismatch($sformatf("irq rose after %0d strobes, expected %0d", got, exp));
		end
	endtask

	task automatic check_irq_level(input logic got, input logic exp);
		checks++;
		if (got !== exp)
			report_mismatch($sformatf("irq is %b, expected %b", got, exp));
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		int n;
		@(negedge clk);
		prg_ain = addr;
		prg_din = data;
		prg_write = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!cpu_ce && n < 6);
		if (!cpu_ce) begin
			errors++;
			test_errors++;
			$display("Write to %h saw no cpu_ce strobe", addr);
		end
		@(negedge clk);
		prg_write = 1'b0;
	endtask

	// Strobes counted from the last write until irq rises
	task automatic wait_irq(output int strobes);
		int cycles;
		strobes = 0;
		cycles = 0;
		while (!irq && cycles < WAIT_CYCLES) begin
			@(posedge clk);
			if (cpu_ce)
				strobes++;
			@(negedge clk);
			cycles++;
		end
		if (!irq)
			strobes = 0;   // Never rose
	endtask

	initial begin
		int          fd;
		int          strobes;
		string       line;
		byte         kind;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		rst = 1'b1;
		cpu_ce = 1'b0;
		ce_div = 2'd0;
		prg_write = 1'b0;
		prg_ain = 16'h0000;
		prg_din = 8'h00;
		chr_ain = 14'h0000;
		board = BOARD_21;
		hard_mirror = 1'b0;
		errors = 0;
		test_errors = 0;
		checks = 0;
		tests = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("tests/vrc4_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the stimulus file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				f0 = '0;
				f1 = '0;
				f2 = '0;
				f3 = '0;
				kind = line[0];
				void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3));
				case (kind)
					"B": begin
						@(negedge clk);
						board = vrc_board_t'(f0[1:0]);
						hard_mirror = f1[0];
						rst = 1'b1;
						repeat (10) @(negedge clk);
						rst = 1'b0;
					end
					"W": write_reg(f0[15:0], f1[7:0]);
					"P": begin
						@(negedge clk);
						prg_ain = f0[15:0];
						prg_write = f1[0];   // Only RAM addresses are written here
						@(posedge clk);
						check_prg(f0[15:0], prg_aout, f2[21:0], prg_allow, f3[0]);
					end
					"C": begin
						@(negedge clk);
						chr_ain = f0[13:0];
						@(posedge clk);
						check_chr(f0[13:0], chr_aout, f1[21:0], {vram_a10, vram_ce},
							{f2[0], f3[0]});
					end
					"Q": begin
						wait_irq(strobes);
						check_irq_count(strobes, int'(f0));
					end
					"A": begin
						@(negedge clk);
						check_irq_level(irq, 1'b0);
					end
					"E": begin
						tests++;
						$display("test %0d %s, %0d errors", f0,
							(test_errors == 0) ? "passed" : "failed", test_errors);
						test_errors = 0;
					end
					default: begin
						errors++;
						$display("Unknown stimulus record: %s", line);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: tests/vrc4_stimulus.txt
# B board hard_mirror | W addr data | P addr write aout allow | C addr aout a10 ce
# Q strobes until irq (0 = never) | A irq low | E test number; all fields hex
B 0 0
A
P 8000 0 000000 1
P A000 0 002000 1
P C000 0 03C000 1
P E123 0 03E123 1
C 0800 200800 1 0
W 8000 05
W 9004 02
P 8000 0 03C000 1
P C010 0 00A010 1
P 6ABC 1 3C0ABC 1
E 1
B 2 1
W D008 0A
W D00C 13
C 1400 24E800 1 0
C 2C00 202C00 1 1
W 9000 03
C 2000 202000 1 1
E 2
B 1 0
W C000 06
W C002 01
C 0800 202C00 1 0
W 9000 00
C 2400 202400 1 1
W F000 0E
W F001 02
Q 0
E 3
B 3 1
W F000 00
W F002 0F
W F001 06
Q 10
W F003 00
A
Q 0
W F000 0E
W F001 02
Q E4
E 4

// File: verilog/reg_wr_if.sv
// Decoded register write

`timescale 1ns/1ps

interface reg_wr_if import vrc_bus_pkg::*; ();

	logic       we;          // One cycle per CPU write
	reg_op_t    op;
	logic [2:0] chr_index;   // CHR bank number for nibble writes
	logic [7:0] data;

	modport source (
		output we, op, chr_index, data
	);

	modport sink (
		input we, op, chr_index, data
	);

endinterface

// File: verilog/vrc4_mapper.sv
// Konami VRC2/VRC4 mapper top

`timescale 1ns/1ps

module vrc4_mapper import vrc_bus_pkg::*, vrc_irq_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        cpu_ce,        // M2 strobe
	input  logic        prg_write,
	input  logic [15:0] prg_ain,
	input  logic [7:0]  prg_din,
	input  logic [13:0] chr_ain,
	input  vrc_board_t  board,
	input  logic        hard_mirror,
	output logic [21:0] prg_aout,
	output logic        prg_allow,
	output logic [21:0] chr_aout,
	output logic        vram_a10,
	output logic        vram_ce,
	output logic        irq
);

	bank_state_t banks;
	irq_state_t  irq_state;
	logic        restart;
	logic        cycle_mode;
	logic        tick;

	reg_wr_if wr_if ();

	vrc_reg_decode vrc_reg_decode_inst (
		.cpu_ce    (cpu_ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.board     (board),
		.wr        (wr_if.source)
	);

	vrc_bank_regs vrc_bank_regs_inst (
		.clk         (clk),
		.rst         (rst),
		.hard_mirror (hard_mirror),
		.wr          (wr_if.sink),
		.banks       (banks)
	);

	vrc_addr_map vrc_addr_map_inst (
		.banks     (banks),
		.board     (board),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

	vrc_irq_prescaler vrc_irq_prescaler_inst (
		.clk        (clk),
		.rst        (rst),
		.cpu_ce     (cpu_ce),
		.restart    (restart),
		.state      (irq_state),
		.cycle_mode (cycle_mode),
		.tick       (tick)
	);

	vrc_irq_fsm vrc_irq_fsm_inst (
		.clk        (clk),
		.rst        (rst),
		.tick       (tick),
		.wr         (wr_if.sink),
		.state      (irq_state),
		.restart    (restart),
		.cycle_mode (cycle_mode),
		.irq        (irq)
	);

endmodule

// File: verilog/vrc_addr_map.sv
// PRG, CHR and CIRAM address translation

`timescale 1ns/1ps
`include "vrc_defs.svh"

module vrc_addr_map import vrc_bus_pkg::*; (
	input  bank_state_t banks,
	input  vrc_board_t  board,
	input  logic [15:0] prg_ain,
	input  logic        prg_write,
	input  logic [13:0] chr_ain,
	output logic [21:0] prg_aout,
	output logic        prg_allow,
	output logic [21:0] chr_aout,
	output logic        vram_a10,
	output logic        vram_ce
);

	logic [`VRC_PRG_BANK_W-1:0] prg_bank;
	logic [`VRC_CHR_BANK_W-1:0] chr_bank;
	logic [`VRC_CHR_BANK_W-1:0] chr_page;
	logic                       prg_is_ram;

	// Swap mode trades the 0x8000 and 0xC000 windows
	always_comb begin
		casez ({prg_ain[14:13], banks.prg_swap})
			3'b00_0: prg_bank = banks.prg0;
			3'b00_1: prg_bank = `VRC_PRG_FIXED_2ND_LAST;
			3'b01_?: prg_bank = banks.prg1;
			3'b10_0: prg_bank = `VRC_PRG_FIXED_2ND_LAST;
			3'b10_1: prg_bank = banks.prg0;
			default: prg_bank = `VRC_PRG_FIXED_LAST;
		endcase
	end

	assign prg_is_ram = (prg_ain[15:13] == 3'b011);   // 0x6000-0x7FFF
	assign prg_allow  = (prg_ain[15] & ~prg_write) | prg_is_ram;
	assign prg_aout   = prg_is_ram ? `VRC_PRG_RAM_BASE + 22'(prg_ain[12:0])
	                               : 22'({prg_bank, prg_ain[12:0]});

	assign vram_ce  = chr_ain[13];
	assign chr_bank = banks.chr[chr_ain[12:10]];

	// Board 22 ignores the lowest CHR bank bit
	always_comb begin
		if (vram_ce)
			chr_page = {{(`VRC_CHR_BANK_W - 4){1'b0}}, chr_ain[13:10]};
		else if (board == BOARD_22)
			chr_page = chr_bank >> 1;
		else
			chr_page = chr_bank;
	end

	assign chr_aout = `VRC_CHR_BASE + 22'({chr_page, chr_ain[9:0]});

	always_comb begin
		case (banks.mirror)
			2'b00:   vram_a10 = chr_ain[10];       // Vertical
			2'b01:   vram_a10 = chr_ain[11];       // Horizontal
			default: vram_a10 = banks.mirror[0];   // One-screen
		endcase
	end

endmodule

// File: verilog/vrc_bank_regs.sv
// PRG, CHR and mirroring registers

`timescale 1ns/1ps

module vrc_bank_regs import vrc_bus_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        hard_mirror,
	reg_wr_if.sink      wr,
	output bank_state_t banks
);

	always_ff @(posedge clk) begin
		if (rst) begin
			banks.prg0     <= 5'd0;
			banks.prg1     <= 5'd1;
			banks.mirror   <= {1'b0, ~hard_mirror};   // Vertical or horizontal
			banks.prg_swap <= 1'b0;
			for (int i = 0; i < 8; i++) begin
				banks.chr[i] <= 9'(i);   // Identity CHR layout
			end
		end else if (wr.we) begin
			case (wr.op)
				OP_PRG0: begin
					banks.prg0 <= wr.data[4:0];
				end
				OP_PRG1: begin
					banks.prg1 <= wr.data[4:0];
				end
				OP_MIRROR_VRC2: begin
					banks.mirror[0] <= wr.data[0];   // V/H select only
				end
				OP_MIRROR_VRC4: begin
					banks.mirror <= wr.data[1:0];
				end
				OP_PRG_MODE: begin
					banks.prg_swap <= wr.data[1];
				end
				OP_CHR_LO: begin
					banks.chr[wr.chr_index][3:0] <= wr.data[3:0];
				end
				OP_CHR_HI: begin
					banks.chr[wr.chr_index][8:4] <= wr.data[4:0];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: verilog/vrc_bus_pkg.sv
// Mapper bus and bank types

`include "vrc_defs.svh"

package vrc_bus_pkg;

	// Board variant, picks the register select lines
	typedef enum logic [1:0] {
		BOARD_21,
		BOARD_22,
		BOARD_23,
		BOARD_25
	} vrc_board_t;

	// Decoded register operation of one CPU write
	typedef enum logic [3:0] {
		OP_NONE,
		OP_PRG0,
		OP_PRG1,
		OP_MIRROR_VRC2,   // 1 bit, VRC2 style
		OP_MIRROR_VRC4,   // 2 bits incl. one-screen
		OP_PRG_MODE,      // Swap bit only
		OP_CHR_LO,
		OP_CHR_HI,
		OP_IRQ_LATCH_LO,
		OP_IRQ_LATCH_HI,
		OP_IRQ_CTRL,
		OP_IRQ_ACK
	} reg_op_t;

	typedef struct packed {
		logic [`VRC_PRG_BANK_W-1:0]       prg0;
		logic [`VRC_PRG_BANK_W-1:0]       prg1;
		logic [7:0][`VRC_CHR_BANK_W-1:0]  chr;     // 1 KB pages
		logic [1:0]                       mirror;
		logic                             prg_swap;
	} bank_state_t;

endpackage

// File: verilog/vrc_defs.svh
// VRC2/VRC4 mapper constants

`ifndef VRC_DEFS_SVH
`define VRC_DEFS_SVH

// Bank register widths
`define VRC_PRG_BANK_W 5
`define VRC_CHR_BANK_W 9

// Last two 8 KB PRG windows are hardwired
`define VRC_PRG_FIXED_2ND_LAST 5'h1E
`define VRC_PRG_FIXED_LAST     5'h1F

// Base offsets on the mapped address buses
`define VRC_PRG_RAM_BASE 22'h3C0000
`define VRC_CHR_BASE     22'h200000

// Scanline prescaler reload values, in cpu_ce strobes
`define VRC_IRQ_PRESCALE_LONG  7'd113
`define VRC_IRQ_PRESCALE_SHORT 7'd112

`endif

// File: verilog/vrc_irq_fsm.sv
// VRC4 IRQ counter and state machine

`timescale 1ns/1ps

module vrc_irq_fsm import vrc_bus_pkg::*, vrc_irq_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       tick,
	reg_wr_if.sink     wr,
	output irq_state_t state,
	output logic       restart,
	output logic       cycle_mode,
	output logic       irq
);

	logic [7:0] latch;
	logic [7:0] counter;
	logic       ack_enable;   // A bit, state to resume on ack
	logic       ctrl_wr;
	logic       ack_wr;

	assign ctrl_wr = wr.we && (wr.op == OP_IRQ_CTRL);
	assign ack_wr  = wr.we && (wr.op == OP_IRQ_ACK);
	assign restart = ctrl_wr & wr.data[1];
	assign irq     = (state == IRQ_FIRED);

	always_ff @(posedge clk) begin
		if (rst) begin
			latch <= 8'd0;
		end else if (wr.we && wr.op == OP_IRQ_LATCH_LO) begin
			latch[3:0] <= wr.data[3:0];
		end else if (wr.we && wr.op == OP_IRQ_LATCH_HI) begin
			latch[7:4] <= wr.data[3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle_mode <= 1'b0;
			ack_enable <= 1'b0;
		end else if (ctrl_wr) begin
			cycle_mode <= wr.data[2];
			ack_enable <= wr.data[0];
		end
	end

	// Register writes take priority over a counter tick
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IRQ_IDLE;
			counter <= 8'd0;
		end else if (ctrl_wr) begin
			if (wr.data[1]) begin
				counter <= latch;
				state   <= IRQ_COUNT;
			end else begin
				state <= IRQ_IDLE;
			end
		end else if (ack_wr) begin
			state <= ack_enable ? IRQ_COUNT : IRQ_IDLE;
		end else if (tick && state != IRQ_IDLE) begin
			if (counter == 8'hFF) begin
				counter <= latch;     // Overflow reloads and fires
				state   <= IRQ_FIRED;
			end else begin
				counter <= counter + 8'd1;
			end
		end
	end

endmodule

// File: verilog/vrc_irq_pkg.sv
// VRC4 IRQ types

package vrc_irq_pkg;

	typedef enum logic [1:0] {
		IRQ_IDLE,    // Counter stopped
		IRQ_COUNT,   // Counting, no request
		IRQ_FIRED    // Counting, request pending
	} irq_state_t;

endpackage

// File: verilog/vrc_irq_prescaler.sv
// VRC4 scanline prescaler

`timescale 1ns/1ps
`include "vrc_defs.svh"

module vrc_irq_prescaler import vrc_irq_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       cpu_ce,
	input  logic       restart,
	input  irq_state_t state,
	input  logic       cycle_mode,
	output logic       tick
);

	logic [6:0] count;
	logic [1:0] line;   // Phase within a three-line group

	assign tick = cpu_ce & (cycle_mode | (count == 7'd0));

	// Reloads give a 114/114/113 strobe period per line
	always_ff @(posedge clk) begin
		if (rst || restart) begin
			count <= `VRC_IRQ_PRESCALE_LONG;
			line  <= 2'd0;
		end else if (cpu_ce && state != IRQ_IDLE) begin
			if (count != 7'd0) begin
				count <= count - 7'd1;
			end else begin
				count <= (line == 2'd1) ? `VRC_IRQ_PRESCALE_SHORT : `VRC_IRQ_PRESCALE_LONG;
				line  <= (line == 2'd2) ? 2'd0 : line + 2'd1;
			end
		end
	end

endmodule

// File: verilog/vrc_reg_decode.sv
// VRC register write decoder

`timescale 1ns/1ps

module vrc_reg_decode import vrc_bus_pkg::*; (
	input  logic        cpu_ce,
	input  logic        prg_write,
	input  logic [15:0] prg_ain,
	input  logic [7:0]  prg_din,
	input  vrc_board_t  board,
	reg_wr_if.source    wr
);

	logic       r1;
	logic       r0;
	logic [2:0] sel;
	logic [1:0] chr_row;
	reg_op_t    op;

	assign sel = prg_ain[14:12];
	assign chr_row = sel[1:0] - 2'd3;   // 3..6 maps to 0..3

	// Each board wires different CPU lines to the register select pins
	always_comb begin
		case (board)
			BOARD_21: begin
				r1 = prg_ain[7] | prg_ain[2];
				r0 = prg_ain[6] | prg_ain[1];
			end
			BOARD_22: begin
				r1 = prg_ain[0];
				r0 = prg_ain[1];
			end
			BOARD_23: begin
				r1 = prg_ain[3] | prg_ain[1];
				r0 = prg_ain[2] | prg_ain[0];
			end
			default: begin
				r1 = prg_ain[2] | prg_ain[0];
				r0 = prg_ain[3] | prg_ain[1];
			end
		endcase
	end

	always_comb begin
		op = OP_NONE;
		case (sel)
			3'd0: op = OP_PRG0;
			3'd1: begin
				if (board == BOARD_22)
					op = OP_MIRROR_VRC2;
				else if (r1)
					op = OP_PRG_MODE;
				else
					op = OP_MIRROR_VRC4;
			end
			3'd2: op = OP_PRG1;
			3'd7: begin
				if (board != BOARD_22) begin   // VRC2 has no IRQ
					case ({r1, r0})
						2'b00:   op = OP_IRQ_LATCH_LO;
						2'b01:   op = OP_IRQ_LATCH_HI;
						2'b10:   op = OP_IRQ_CTRL;
						default: op = OP_IRQ_ACK;
					endcase
				end
			end
			default: op = r0 ? OP_CHR_HI : OP_CHR_LO;
		endcase
	end

	assign wr.we        = cpu_ce & prg_write & prg_ain[15];
	assign wr.op        = op;
	assign wr.chr_index = {chr_row, r1};
	assign wr.data      = prg_din;

endmodule
